// File: Bender.yml
package:
  name: eye_tracker

sources:
  - include_dirs:
      - design
    files:
      - design/eye_pkg.sv
      - design/camera_input.sv
      - design/gravity_accum.sv
      - design/gravity_divider.sv
      - design/eye_tracker_reg.sv
      - design/eye_tracker_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/eye_checker.sv
      - tb/tb_eye_tracker.sv

// File: design/camera_input.sv
`include "eye_settings.svh"

module camera_input import eye_pkg::*; (
    input  logic   cclk,
    input  logic   arst_n,
    input  logic   fval,
    input  logic   lval,
    input  logic   dval,
    input  pixel_t data_l,
    input  pixel_t data_r,
    output logic   pix_valid,
    output logic   frame_start,
    output logic   frame_end,
    output coord_t pix_x,
    output coord_t pix_y,
    output pixel_t pix_l,
    output pixel_t pix_r
);

    logic   dval_act;
    logic   fval_q;
    logic   lval_q;
    logic   fval_rise;
    logic   fval_fall;
    logic   lval_rise;
    logic   lval_fall;
    logic   pair_valid;
    coord_t col_cnt;
    coord_t row_cnt;
    coord_t col_base;
    coord_t row_base;

    // fixed strobe polarity
    assign dval_act = (`DVAL_ACTIVE_LOW != 0) ? ~dval : dval;

    // --------------------
    // strobe edges
    // --------------------
    assign fval_rise = fval & ~fval_q;
    assign fval_fall = ~fval & fval_q;
    assign lval_rise = lval & ~lval_q;
    assign lval_fall = ~lval & lval_q;

    assign pair_valid = fval & lval & dval_act;

    // column restarts on each new line, row on each new frame
    assign col_base = lval_rise ? '0 : col_cnt;
    assign row_base = fval_rise ? '0 : row_cnt;

    always_ff @(posedge cclk or negedge arst_n) begin
        if (!arst_n) begin
            fval_q      <= 1'b0;
            lval_q      <= 1'b0;
            pix_valid   <= 1'b0;
            frame_start <= 1'b0;
            frame_end   <= 1'b0;
            col_cnt     <= '0;
            row_cnt     <= '0;
        end else begin
            fval_q      <= fval;
            lval_q      <= lval;
            pix_valid   <= pair_valid;
            frame_start <= fval_rise;
            frame_end   <= fval_fall;
            // two taps, so the column steps by two
            if (pair_valid) begin
                col_cnt <= col_base + coord_t'(2);
            end else begin
                col_cnt <= col_base;
            end
            if (fval_rise) begin
                row_cnt <= '0;
            end else if (lval_fall) begin
                row_cnt <= row_cnt + coord_t'(1);
            end
        end
    end

    // pixel payload, aligned with pix_valid
    always_ff @(posedge cclk) begin
        pix_x <= col_base;
        pix_y <= row_base;
        pix_l <= data_l;
        pix_r <= data_r;
    end

endmodule

// File: design/eye_pkg.sv
`include "eye_settings.svh"

package eye_pkg;

    // --------------------
    // video side
    // --------------------
    typedef logic [`PIXEL_WIDTH-1:0]     pixel_t;
    typedef logic [`COORD_WIDTH-1:0]     coord_t;

    // frame moments and centroid quotients
    typedef logic [`SUM_S_WIDTH-1:0]     sum_s_t;
    typedef logic [`SUM_XY_WIDTH-1:0]    sum_xy_t;

    // --------------------
    // host side
    // --------------------
    typedef logic [`HOST_ADDR_WIDTH-1:0] host_addr_t;
    typedef logic [`HOST_DATA_WIDTH-1:0] host_data_t;

    // serial divider FSM
    typedef enum logic [1:0] {
        div_idle,
        div_run,
        div_done
    } div_state_t;

endpackage

// File: design/eye_settings.svh
`ifndef EYE_SETTINGS_SVH
`define EYE_SETTINGS_SVH

// --------------------
// data path widths
// --------------------
`define PIXEL_WIDTH         8
`define COORD_WIDTH         10
`define SUM_S_WIDTH         20
`define SUM_XY_WIDTH        28

// host bus
`define HOST_ADDR_WIDTH     4
`define HOST_DATA_WIDTH     32

// binarization level after reset
`define DEFAULT_THRESHOLD   128

// camera link strobes, fval and lval are active high
`define DVAL_ACTIVE_LOW     1

// --------------------
// register map
// --------------------
`define REG_THRESHOLD       4'h0
`define REG_SUM_S           4'h1
`define REG_SUM_SX          4'h2
`define REG_SUM_SY          4'h3
`define REG_CENTROID_X      4'h4
`define REG_CENTROID_Y      4'h5
`define REG_FRAME_COUNT     4'h6

`endif

// File: design/eye_tracker_reg.sv
`include "eye_settings.svh"

module eye_tracker_reg import eye_pkg::*; (
    input  logic       cclk,
    input  logic       arst_n,
    input  host_addr_t host_addr,
    input  logic       host_we,
    input  logic       host_re,
    input  host_data_t host_wdata,
    output host_data_t host_rdata,
    output logic       host_rvalid,
    input  sum_s_t     sum_s,
    input  sum_xy_t    sum_sx,
    input  sum_xy_t    sum_sy,
    input  sum_xy_t    centroid_x,
    input  sum_xy_t    centroid_y,
    input  logic       centroid_valid,
    output pixel_t     threshold
);

    host_data_t frame_count;
    host_data_t rd_mux;
    logic       thr_wr;

    // only the threshold is writable
    assign thr_wr = host_we && (host_addr == `REG_THRESHOLD);

    // --------------------
    // read decode
    // --------------------
    always_comb begin
        case (host_addr)
            `REG_THRESHOLD:   rd_mux = host_data_t'(threshold);
            `REG_SUM_S:       rd_mux = host_data_t'(sum_s);
            `REG_SUM_SX:      rd_mux = host_data_t'(sum_sx);
            `REG_SUM_SY:      rd_mux = host_data_t'(sum_sy);
            `REG_CENTROID_X:  rd_mux = host_data_t'(centroid_x);
            `REG_CENTROID_Y:  rd_mux = host_data_t'(centroid_y);
            `REG_FRAME_COUNT: rd_mux = frame_count;
            // holes in the map
            default:          rd_mux = '0;
        endcase
    end

    // --------------------
    // threshold and frame counter
    // --------------------
    always_ff @(posedge cclk or negedge arst_n) begin
        if (!arst_n) begin
            threshold   <= pixel_t'(`DEFAULT_THRESHOLD);
            frame_count <= '0;
        end else begin
            if (thr_wr) begin
                threshold <= host_wdata[`PIXEL_WIDTH-1:0];
            end
            // one count per finished centroid
            if (centroid_valid) begin
                frame_count <= frame_count + 1'b1;
            end
        end
    end

    // read data returns one cycle after host_re
    always_ff @(posedge cclk or negedge arst_n) begin
        if (!arst_n) begin
            host_rvalid <= 1'b0;
            host_rdata  <= '0;
        end else begin
            host_rvalid <= host_re;
            if (host_re) begin
                host_rdata <= rd_mux;
            end
        end
    end

endmodule

// File: design/eye_tracker_top.sv
`include "eye_settings.svh"

module eye_tracker_top import eye_pkg::*; (
    input  logic       cclk,
    input  logic       arst_n,
    // camera link
    input  logic       fval,
    input  logic       lval,
    input  logic       dval,
    input  pixel_t     data_l,
    input  pixel_t     data_r,
    // host bus
    input  host_addr_t host_addr,
    input  logic       host_we,
    input  logic       host_re,
    input  host_data_t host_wdata,
    output host_data_t host_rdata,
    output logic       host_rvalid,
    // centre of gravity
    output logic       centroid_valid,
    output coord_t     centroid_x,
    output coord_t     centroid_y
);

    logic    pix_valid;
    logic    frame_start;
    logic    frame_end;
    coord_t  pix_x;
    coord_t  pix_y;
    pixel_t  pix_l;
    pixel_t  pix_r;
    pixel_t  threshold;
    sum_s_t  sum_s;
    sum_xy_t sum_sx;
    sum_xy_t sum_sy;
    logic    sums_valid;
    sum_xy_t quot_x;
    sum_xy_t quot_y;

    // quotients never exceed the coordinate range
    assign centroid_x = quot_x[`COORD_WIDTH-1:0];
    assign centroid_y = quot_y[`COORD_WIDTH-1:0];

    camera_input u_camera_input (
        .cclk        (cclk),
        .arst_n      (arst_n),
        .fval        (fval),
        .lval        (lval),
        .dval        (dval),
        .data_l      (data_l),
        .data_r      (data_r),
        .pix_valid   (pix_valid),
        .frame_start (frame_start),
        .frame_end   (frame_end),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .pix_l       (pix_l),
        .pix_r       (pix_r)
    );

    gravity_accum u_gravity_accum (
        .cclk        (cclk),
        .arst_n      (arst_n),
        .pix_valid   (pix_valid),
        .frame_start (frame_start),
        .frame_end   (frame_end),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .pix_l       (pix_l),
        .pix_r       (pix_r),
        .threshold   (threshold),
        .sum_s       (sum_s),
        .sum_sx      (sum_sx),
        .sum_sy      (sum_sy),
        .sums_valid  (sums_valid)
    );

    gravity_divider u_gravity_divider (
        .cclk           (cclk),
        .arst_n         (arst_n),
        .sums_valid     (sums_valid),
        .sum_s          (sum_s),
        .sum_sx         (sum_sx),
        .sum_sy         (sum_sy),
        .centroid_x     (quot_x),
        .centroid_y     (quot_y),
        .centroid_valid (centroid_valid)
    );

    eye_tracker_reg u_eye_tracker_reg (
        .cclk           (cclk),
        .arst_n         (arst_n),
        .host_addr      (host_addr),
        .host_we        (host_we),
        .host_re        (host_re),
        .host_wdata     (host_wdata),
        .host_rdata     (host_rdata),
        .host_rvalid    (host_rvalid),
        .sum_s          (sum_s),
        .sum_sx         (sum_sx),
        .sum_sy         (sum_sy),
        .centroid_x     (quot_x),
        .centroid_y     (quot_y),
        .centroid_valid (centroid_valid),
        .threshold      (threshold)
    );

endmodule

// File: design/gravity_accum.sv
`include "eye_settings.svh"

module gravity_accum import eye_pkg::*; (
    input  logic    cclk,
    input  logic    arst_n,
    input  logic    pix_valid,
    input  logic    frame_start,
    input  logic    frame_end,
    input  coord_t  pix_x,
    input  coord_t  pix_y,
    input  pixel_t  pix_l,
    input  pixel_t  pix_r,
    input  pixel_t  threshold,
    output sum_s_t  sum_s,
    output sum_xy_t sum_sx,
    output sum_xy_t sum_sy,
    output logic    sums_valid
);

    pixel_t  thr_frame;
    pixel_t  thr_eff;
    logic    bright_l;
    logic    bright_r;
    sum_s_t  s_acc;
    sum_xy_t sx_acc;
    sum_xy_t sy_acc;
    sum_s_t  s_add;
    sum_xy_t sx_add;
    sum_xy_t sy_add;

    // first pixels of a frame may share the cycle with frame_start
    assign thr_eff = frame_start ? threshold : thr_frame;

    // --------------------
    // binarize both taps
    // --------------------
    assign bright_l = pix_valid && (pix_l >= thr_eff);
    assign bright_r = pix_valid && (pix_r >= thr_eff);

    // right tap sits one column to the right
    assign s_add  = sum_s_t'(bright_l) + sum_s_t'(bright_r);
    assign sx_add = (bright_l ? sum_xy_t'(pix_x) : '0)
                  + (bright_r ? sum_xy_t'(pix_x) + sum_xy_t'(1) : '0);
    assign sy_add = (bright_l ? sum_xy_t'(pix_y) : '0)
                  + (bright_r ? sum_xy_t'(pix_y) : '0);

    // --------------------
    // accumulate and latch
    // --------------------
    always_ff @(posedge cclk or negedge arst_n) begin
        if (!arst_n) begin
            thr_frame  <= pixel_t'(`DEFAULT_THRESHOLD);
            s_acc      <= '0;
            sx_acc     <= '0;
            sy_acc     <= '0;
            sum_s      <= '0;
            sum_sx     <= '0;
            sum_sy     <= '0;
            sums_valid <= 1'b0;
        end else begin
            sums_valid <= frame_end;
            if (frame_start) begin
                thr_frame <= threshold;
            end
            // cleared here, so the next frame starts from zero
            if (frame_end) begin
                sum_s  <= s_acc;
                sum_sx <= sx_acc;
                sum_sy <= sy_acc;
                s_acc  <= '0;
                sx_acc <= '0;
                sy_acc <= '0;
            end else begin
                s_acc  <= s_acc + s_add;
                sx_acc <= sx_acc + sx_add;
                sy_acc <= sy_acc + sy_add;
            end
        end
    end

endmodule

// File: design/gravity_divider.sv
`include "eye_settings.svh"

module gravity_divider import eye_pkg::*; (
    input  logic    cclk,
    input  logic    arst_n,
    input  logic    sums_valid,
    input  sum_s_t  sum_s,
    input  sum_xy_t sum_sx,
    input  sum_xy_t sum_sy,
    output sum_xy_t centroid_x,
    output sum_xy_t centroid_y,
    output logic    centroid_valid
);

    localparam int cnt_width = $clog2(`SUM_XY_WIDTH);
    localparam int last_bit  = `SUM_XY_WIDTH - 1;

    div_state_t             state;
    logic [cnt_width-1:0]   bit_cnt;
    sum_xy_t                divisor;
    sum_xy_t                rem_x;
    sum_xy_t                quo_x;
    sum_xy_t                rem_y;
    sum_xy_t                quo_y;
    sum_xy_t                rem_x_nxt;
    sum_xy_t                quo_x_nxt;
    sum_xy_t                rem_y_nxt;
    sum_xy_t                quo_y_nxt;

    // one restoring step, returns {remainder, quotient}
    function automatic logic [2*`SUM_XY_WIDTH-1:0] div_step(
        input sum_xy_t rem,
        input sum_xy_t quo,
        input sum_xy_t dvs
    );
        logic [`SUM_XY_WIDTH:0] trial;
        logic                   fits;
        trial = {rem, quo[last_bit]};
        fits  = (trial >= {1'b0, dvs});
        if (fits) begin
            trial = trial - {1'b0, dvs};
        end
        return {trial[`SUM_XY_WIDTH-1:0], quo[last_bit-1:0], fits};
    endfunction

    // both quotient paths share the divisor
    always_comb begin
        {rem_x_nxt, quo_x_nxt} = div_step(rem_x, quo_x, divisor);
        {rem_y_nxt, quo_y_nxt} = div_step(rem_y, quo_y, divisor);
    end

    // --------------------
    // control
    // --------------------
    always_ff @(posedge cclk or negedge arst_n) begin
        if (!arst_n) begin
            state          <= div_idle;
            bit_cnt        <= '0;
            centroid_valid <= 1'b0;
            centroid_x     <= '0;
            centroid_y     <= '0;
        end else begin
            centroid_valid <= 1'b0;
            case (state)
                div_idle: begin
                    // busy divider drops a new request
                    if (sums_valid) begin
                        bit_cnt <= '0;
                        state   <= div_run;
                    end
                end
                div_run: begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == cnt_width'(last_bit)) begin
                        state <= div_done;
                    end
                end
                div_done: begin
                    // empty frame gives a zero centroid
                    centroid_x     <= (divisor == '0) ? '0 : quo_x;
                    centroid_y     <= (divisor == '0) ? '0 : quo_y;
                    centroid_valid <= 1'b1;
                    state          <= div_idle;
                end
                default: begin
                    state <= div_idle;
                end
            endcase
        end
    end

    // --------------------
    // datapath
    // --------------------
    always_ff @(posedge cclk) begin
        if (state == div_idle && sums_valid) begin
            divisor <= sum_xy_t'(sum_s);
            rem_x   <= '0;
            quo_x   <= sum_sx;
            rem_y   <= '0;
            quo_y   <= sum_sy;
        end else if (state == div_run) begin
            rem_x <= rem_x_nxt;
            quo_x <= quo_x_nxt;
            rem_y <= rem_y_nxt;
            quo_y <= quo_y_nxt;
        end
    end

endmodule

// File: src.f
+incdir+design
design/eye_pkg.sv
design/camera_input.sv
design/gravity_accum.sv
design/gravity_divider.sv
design/eye_tracker_reg.sv
design/eye_tracker_top.sv
tb/eye_checker.sv
tb/tb_eye_tracker.sv

// File: tb/eye_checker.sv
`include "eye_settings.svh"

module eye_checker (
    input  logic                        cclk,
    input  logic                        arst_n,
    input  logic                        fval,
    input  logic                        lval,
    input  logic                        dval,
    input  logic [`PIXEL_WIDTH-1:0]     data_l,
    input  logic [`PIXEL_WIDTH-1:0]     data_r,
    input  logic [`HOST_ADDR_WIDTH-1:0] host_addr,
    input  logic                        host_we,
    input  logic                        host_re,
    input  logic [`HOST_DATA_WIDTH-1:0] host_wdata,
    input  logic [`HOST_DATA_WIDTH-1:0] host_rdata,
    input  logic                        host_rvalid,
    input  logic                        centroid_valid,
    input  logic [`COORD_WIDTH-1:0]     centroid_x,
    input  logic [`COORD_WIDTH-1:0]     centroid_y,
    output int                          value_errors,
    output int                          protocol_errors,
    output int                          centroids_seen
);
    timeunit 1ns;
    timeprecision 100ps;

    // pixels of the current frame with their coordinates
    int cap_x[$];
    int cap_y[$];
    int cap_v[$];

    int          thr_mirror;
    int          thr_next;
    int          thr_frame;
    int          col;
    int          row;
    logic        fval_p;
    logic        lval_p;
    logic        dval_act;
    logic        rd_pending;
    logic [`HOST_DATA_WIDTH-1:0] rd_expect;
    logic        cent_pending;
    int          cent_wait;
    longint      exp_s;
    longint      exp_sx;
    longint      exp_sy;
    longint      exp_qx;
    longint      exp_qy;
    longint      last_qx;
    longint      last_qy;

    // --------------------
    // reference model
    // --------------------
    function automatic void compute_reference(input int thr, output longint s,
                                              output longint sx, output longint sy,
                                              output longint qx, output longint qy);
        s  = 0;
        sx = 0;
        sy = 0;
        foreach (cap_v[i]) begin
            // equal to the threshold counts as bright
            if (cap_v[i] >= thr) begin
                s  = s + 1;
                sx = sx + cap_x[i];
                sy = sy + cap_y[i];
            end
        end
        qx = (s == 0) ? 0 : sx / s;
        qy = (s == 0) ? 0 : sy / s;
    endfunction

    function automatic logic [`HOST_DATA_WIDTH-1:0] expected_read(input logic [3:0] addr);
        case (addr)
            `REG_THRESHOLD:   return `HOST_DATA_WIDTH'(thr_mirror);
            `REG_SUM_S:       return `HOST_DATA_WIDTH'(exp_s);
            `REG_SUM_SX:      return `HOST_DATA_WIDTH'(exp_sx);
            `REG_SUM_SY:      return `HOST_DATA_WIDTH'(exp_sy);
            `REG_CENTROID_X:  return `HOST_DATA_WIDTH'(last_qx);
            `REG_CENTROID_Y:  return `HOST_DATA_WIDTH'(last_qy);
            `REG_FRAME_COUNT: return `HOST_DATA_WIDTH'(centroids_seen);
            default:          return '0;
        endcase
    endfunction

    task automatic report_value(input string what, input longint got, input longint exp);
        $display("FAILED %0t: %s is %0d, expected %0d", $time, what, got, exp);
        value_errors = value_errors + 1;
    endtask

    task automatic report_protocol(input string msg);
        $display("%s, seen at %0t", msg, $time);
        protocol_errors = protocol_errors + 1;
    endtask

    initial begin
        value_errors    = 0;
        protocol_errors = 0;
        centroids_seen  = 0;
    end

    assign dval_act = (`DVAL_ACTIVE_LOW != 0) ? !dval : dval;

    // --------------------
    // compare on every edge
    // --------------------
    always @(posedge cclk) begin
        if (!arst_n) begin
            thr_mirror   = `DEFAULT_THRESHOLD;
            thr_frame    = `DEFAULT_THRESHOLD;
            fval_p       = 1'b0;
            lval_p       = 1'b0;
            rd_pending   = 1'b0;
            cent_pending = 1'b0;
            cent_wait    = 0;
            col          = 0;
            row          = 0;
            exp_s        = 0;
            exp_sx       = 0;
            exp_sy       = 0;
            last_qx      = 0;
            last_qy      = 0;
            if (centroid_valid || host_rvalid) begin
                report_protocol("centroid_valid or host_rvalid high during reset");
            end
        end else begin
            // host read response, one cycle after host_re
            if (rd_pending) begin
                if (!host_rvalid) begin
                    report_protocol("host_rvalid missing one cycle after host_re");
                end else if (host_rdata !== rd_expect) begin
                    report_value("host_rdata", host_rdata, rd_expect);
                end
            end else if (host_rvalid) begin
                report_protocol("host_rvalid without a read request");
            end
            rd_pending = host_re;
            if (host_re) begin
                rd_expect = expected_read(host_addr);
            end

            // centroid result
            if (centroid_valid) begin
                if (!cent_pending) begin
                    report_protocol("centroid_valid without a finished frame");
                end else begin
                    if (cent_wait != 31) begin
                        report_value("centroid latency", cent_wait, 31);
                    end
                    if (centroid_x !== `COORD_WIDTH'(exp_qx)) begin
                        report_value("centroid_x", centroid_x, exp_qx);
                    end
                    if (centroid_y !== `COORD_WIDTH'(exp_qy)) begin
                        report_value("centroid_y", centroid_y, exp_qy);
                    end
                end
                last_qx        = exp_qx;
                last_qy        = exp_qy;
                cent_pending   = 1'b0;
                centroids_seen = centroids_seen + 1;
            end else if (cent_pending) begin
                cent_wait = cent_wait + 1;
                if (cent_wait > 40) begin
                    report_protocol("no centroid_valid within 40 cycles of frame end");
                    cent_pending = 1'b0;
                end
            end

            // threshold mirror, a write lands on this edge
            thr_next = thr_mirror;
            if (host_we && host_addr == `REG_THRESHOLD) begin
                thr_next = host_wdata[`PIXEL_WIDTH-1:0];
            end

            // camera side coordinate rules
            if (fval && !fval_p) begin
                thr_frame = thr_next;
                row       = 0;
                cap_x.delete();
                cap_y.delete();
                cap_v.delete();
            end else if (!lval && lval_p) begin
                row = row + 1;
            end
            if (lval && !lval_p) begin
                col = 0;
            end
            if (fval && lval && dval_act) begin
                cap_x.push_back(col);
                cap_y.push_back(row);
                cap_v.push_back(data_l);
                cap_x.push_back(col + 1);
                cap_y.push_back(row);
                cap_v.push_back(data_r);
                col = col + 2;
            end
            if (!fval && fval_p) begin
                compute_reference(thr_frame, exp_s, exp_sx, exp_sy, exp_qx, exp_qy);
                cent_pending = 1'b1;
                cent_wait    = 0;
            end

            fval_p     = fval;
            lval_p     = lval;
            thr_mirror = thr_next;
        end
    end

endmodule

// File: tb/tb_eye_tracker.sv
`include "eye_settings.svh"

module tb_eye_tracker;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int pairs_per_line = 16;
    localparam int lines_per_frame = 12;
    localparam int frame_count = 7;
    // worst case frame with a dval gap before every pair, plus readback
    localparam int frame_cycles = 8 + lines_per_frame * (2 * pairs_per_line + 5) + 64 + 90;
    localparam int cycle_limit = 2 * (frame_count * frame_cycles + 60);

    localparam int mode_random = 0;
    localparam int mode_below  = 1;
    localparam int mode_equal  = 2;
    localparam int mode_spot   = 3;

    logic                        cclk;
    logic                        arst_n;
    logic                        fval;
    logic                        lval;
    logic                        dval;
    logic [`PIXEL_WIDTH-1:0]     data_l;
    logic [`PIXEL_WIDTH-1:0]     data_r;
    logic [`HOST_ADDR_WIDTH-1:0] host_addr;
    logic                        host_we;
    logic                        host_re;
    logic [`HOST_DATA_WIDTH-1:0] host_wdata;
    logic [`HOST_DATA_WIDTH-1:0] host_rdata;
    logic                        host_rvalid;
    logic                        centroid_valid;
    logic [`COORD_WIDTH-1:0]     centroid_x;
    logic [`COORD_WIDTH-1:0]     centroid_y;
    int                          value_errors;
    int                          protocol_errors;
    int                          centroids_seen;
    int                          cycle_count;
    logic [31:0]                 lfsr_state;

    eye_tracker_top UUT (
        .cclk           (cclk),
        .arst_n         (arst_n),
        .fval           (fval),
        .lval           (lval),
        .dval           (dval),
        .data_l         (data_l),
        .data_r         (data_r),
        .host_addr      (host_addr),
        .host_we        (host_we),
        .host_re        (host_re),
        .host_wdata     (host_wdata),
        .host_rdata     (host_rdata),
        .host_rvalid    (host_rvalid),
        .centroid_valid (centroid_valid),
        .centroid_x     (centroid_x),
        .centroid_y     (centroid_y)
    );

    eye_checker u_eye_checker (
        .cclk            (cclk),
        .arst_n          (arst_n),
        .fval            (fval),
        .lval            (lval),
        .dval            (dval),
        .data_l          (data_l),
        .data_r          (data_r),
        .host_addr       (host_addr),
        .host_we         (host_we),
        .host_re         (host_re),
        .host_wdata      (host_wdata),
        .host_rdata      (host_rdata),
        .host_rvalid     (host_rvalid),
        .centroid_valid  (centroid_valid),
        .centroid_x      (centroid_x),
        .centroid_y      (centroid_y),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors),
        .centroids_seen  (centroids_seen)
    );

    initial begin
        cclk = 1'b0;
        forever #2 cclk = ~cclk;
    end

    // --------------------
    // random source
    // --------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    function automatic logic [7:0] pixel_value(input int mode, input int x, input int y,
                                               input int spot_x, input int spot_y,
                                               input int level);
        logic [7:0] v;
        case (mode)
            mode_below: begin
                v = take_bits(8);
                if (v == 8'hff) begin
                    v = 8'hfe;
                end
            end
            mode_equal: v = take_bits(1) ? 8'(level) : 8'(level - 1);
            mode_spot:  v = (x == spot_x && y == spot_y) ? 8'd200 : 8'd20;
            default:    v = take_bits(8);
        endcase
        return v;
    endfunction

    // --------------------
    // host bus
    // --------------------
    task automatic host_write(input logic [3:0] addr, input logic [31:0] wdata);
        @(posedge cclk);
        host_we    <= 1'b1;
        host_addr  <= addr;
        host_wdata <= wdata;
        @(posedge cclk);
        host_we    <= 1'b0;
    endtask

    task automatic host_read(input logic [3:0] addr);
        int waited;
        @(posedge cclk);
        host_re   <= 1'b1;
        host_addr <= addr;
        @(posedge cclk);
        host_re   <= 1'b0;
        waited = 0;
        while (!host_rvalid && waited < 8) begin
            @(posedge cclk);
            waited++;
        end
    endtask

    // --------------------
    // camera frames
    // --------------------
    task automatic send_frame(input int mode, input bit vary, input int spot_x,
                              input int spot_y, input int level, input int mid_thr);
        int pairs;
        int p;
        bit wrote;
        wrote = 1'b0;
        @(posedge cclk);
        fval <= 1'b1;
        repeat (3) @(posedge cclk);
        for (int y = 0; y < lines_per_frame; y++) begin
            pairs = vary ? pairs_per_line - (y % 4) * 3 : pairs_per_line;
            p = 0;
            while (p < pairs) begin
                @(posedge cclk);
                lval    <= 1'b1;
                host_we <= 1'b0;
                // threshold change halfway through the frame
                if (mid_thr >= 0 && y == lines_per_frame / 2 && !wrote) begin
                    host_we    <= 1'b1;
                    host_addr  <= `REG_THRESHOLD;
                    host_wdata <= mid_thr;
                    wrote = 1'b1;
                end
                if (take_bits(1) == 32'd1) begin
                    // idle tap cycle, bright junk must be ignored
                    dval   <= 1'b1;
                    data_l <= 8'hff;
                    data_r <= 8'hff;
                end else begin
                    dval   <= 1'b0;
                    data_l <= pixel_value(mode, 2 * p, y, spot_x, spot_y, level);
                    data_r <= pixel_value(mode, 2 * p + 1, y, spot_x, spot_y, level);
                    p++;
                end
            end
            @(posedge cclk);
            lval    <= 1'b0;
            dval    <= 1'b1;
            host_we <= 1'b0;
            repeat (3) @(posedge cclk);
        end
        repeat (2) @(posedge cclk);
        fval <= 1'b0;
    endtask

    task automatic read_results();
        int waited;
        waited = 0;
        @(posedge cclk);
        while (!centroid_valid && waited < 64) begin
            @(posedge cclk);
            waited++;
        end
        host_read(`REG_SUM_S);
        host_read(`REG_SUM_SX);
        host_read(`REG_SUM_SY);
        host_read(`REG_CENTROID_X);
        host_read(`REG_CENTROID_Y);
        host_read(`REG_FRAME_COUNT);
        repeat (20) @(posedge cclk);
    endtask

    // --------------------
    // test sequence
    // --------------------
    initial begin
        arst_n     = 1'b0;
        fval       = 1'b0;
        lval       = 1'b0;
        dval       = 1'b1;
        data_l     = '0;
        data_r     = '0;
        host_addr  = '0;
        host_we    = 1'b0;
        host_re    = 1'b0;
        host_wdata = '0;
        lfsr_state = 32'he4b4_700f;
        repeat (2) @(posedge cclk);
        arst_n <= 1'b1;
        @(posedge cclk);

        // reset values, a hole in the map, a read-only write
        host_read(`REG_THRESHOLD);
        host_read(`REG_FRAME_COUNT);
        host_read(4'hc);
        host_write(`REG_SUM_S, 32'h0000_1234);
        host_read(`REG_SUM_S);

        send_frame(mode_random, 1'b0, 0, 0, 0, -1);
        read_results();
        send_frame(mode_random, 1'b0, 0, 0, 0, -1);
        read_results();

        // nothing reaches 255
        host_write(`REG_THRESHOLD, 32'd255);
        host_read(`REG_THRESHOLD);
        send_frame(mode_below, 1'b0, 0, 0, 0, -1);
        read_results();

        // new threshold only from the next frame on
        host_write(`REG_THRESHOLD, 32'd128);
        send_frame(mode_random, 1'b0, 0, 0, 0, 100);
        read_results();
        send_frame(mode_equal, 1'b0, 0, 0, 100, -1);
        read_results();

        // single spot, ragged lines
        host_write(`REG_THRESHOLD, 32'd128);
        send_frame(mode_spot, 1'b1, 13, 7, 0, -1);
        read_results();
        send_frame(mode_spot, 1'b1, 6, 10, 0, -1);
        read_results();

        $display("errors: %0d value, %0d protocol, %0d centroids seen",
                 value_errors, protocol_errors, centroids_seen);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // run limit
    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge cclk);
            cycle_count++;
        end
        $display("run stopped after %0d cycles without finishing", cycle_count);
        $display("errors: %0d value, %0d protocol, %0d centroids seen",
                 value_errors, protocol_errors, centroids_seen);
        $display("TEST FAILED");
        $finish;
    end

endmodule
